//--- build.f
src/accel_pkg.sv
src/fetch_cfg_if.sv
src/pair_stream_if.sv
src/word_sram.sv
src/instr_ctrl.sv
src/operand_fetch.sv
src/result_writer.sv
src/accel_top.sv
test/tb_accel.sv

//--- run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f build.f --top-module tb_accel -o tb_accel
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_accel > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0

//--- src/accel_pkg.sv
`default_nettype none

package accel_pkg;

    localparam int WORD_W    = 16;
    localparam int ADDR_W    = 10;
    localparam int BUF_DEPTH = 1024;
    localparam int DIM_W     = 8;
    localparam int COUNT_W   = 24;

    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [DIM_W-1:0]   dim_t;
    typedef logic [COUNT_W-1:0] count_t;

    // one 34-bit region of a buffer
    typedef struct packed {
        addr_t src_addr;
        dim_t  channel;
        dim_t  row;
        dim_t  col;
    } desc_t;

    typedef enum logic [2:0] {
        OP_CONFIG = 3'b000,
        OP_CONV   = 3'b001,
        OP_MATRIX = 3'b010
    } op_t;

    // 105-bit host instruction with op in the top bits
    typedef struct packed {
        op_t   op;
        desc_t wb_desc;
        desc_t a_desc;
        desc_t b_desc;
    } instr_t;

endpackage

`default_nettype wire

//--- src/accel_top.sv
`default_nettype none

module accel_top import accel_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire         instr_valid,
    input  wire instr_t instr,
    input  wire         load_en,
    input  wire         load_sel,
    input  wire addr_t  load_addr,
    input  wire word_t  load_data,
    input  wire addr_t  rd_addr,
    output wire         ack,
    output wire         done,
    output wire word_t  out_a,
    output wire word_t  out_b
);

    fetch_cfg_if   cfg_bus ();
    pair_stream_if pair_bus ();

    wire   a_load_en;
    wire   b_load_en;
    addr_t a_rd_addr;
    addr_t b_rd_addr;
    word_t a_rd_data;
    word_t b_rd_data;
    wire   res_wr_en;
    addr_t res_wr_addr;
    word_t res_wr_a;
    word_t res_wr_b;

    // load_sel low targets A, high targets B
    assign a_load_en = load_en & ~load_sel;
    assign b_load_en = load_en & load_sel;

    instr_ctrl i_instr_ctrl (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .ack         (ack),
        .cfg         (cfg_bus.ctrl)
    );

    operand_fetch i_operand_fetch (
        .clk       (clk),
        .rst       (rst),
        .cfg       (cfg_bus.fetch),
        .a_rd_addr (a_rd_addr),
        .a_rd_data (a_rd_data),
        .b_rd_addr (b_rd_addr),
        .b_rd_data (b_rd_data),
        .pairs     (pair_bus.src)
    );

    result_writer i_result_writer (
        .clk     (clk),
        .rst     (rst),
        .pairs   (pair_bus.dst),
        .wr_en   (res_wr_en),
        .wr_addr (res_wr_addr),
        .wr_a    (res_wr_a),
        .wr_b    (res_wr_b),
        .done    (done)
    );

    word_sram a_buf (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (a_load_en),
        .wr_addr (load_addr),
        .wr_data (load_data),
        .rd_addr (a_rd_addr),
        .rd_data (a_rd_data)
    );

    word_sram b_buf (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (b_load_en),
        .wr_addr (load_addr),
        .wr_data (load_data),
        .rd_addr (b_rd_addr),
        .rd_data (b_rd_data)
    );

    // both output buffers share the write address and the host rd_addr
    word_sram out_a_buf (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (res_wr_en),
        .wr_addr (res_wr_addr),
        .wr_data (res_wr_a),
        .rd_addr (rd_addr),
        .rd_data (out_a)
    );

    word_sram out_b_buf (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (res_wr_en),
        .wr_addr (res_wr_addr),
        .wr_data (res_wr_b),
        .rd_addr (rd_addr),
        .rd_data (out_b)
    );

endmodule

`default_nettype wire

//--- src/fetch_cfg_if.sv
`default_nettype none

interface fetch_cfg_if import accel_pkg::*; ();

    logic  req;
    logic  ack;
    desc_t a_desc;
    desc_t b_desc;

    // descriptors stay stable while req is high
    modport ctrl (
        output req,
        output a_desc,
        output b_desc,
        input  ack
    );

    modport fetch (
        input  req,
        input  a_desc,
        input  b_desc,
        output ack
    );

endinterface

`default_nettype wire

//--- src/instr_ctrl.sv
`default_nettype none

module instr_ctrl import accel_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire         instr_valid,
    input  wire instr_t instr,
    output logic        ack,
    fetch_cfg_if.ctrl   cfg
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DISPATCH,
        ST_ACKED
    } state_t;

    state_t state;
    op_t    op;
    desc_t  a_desc_q;
    desc_t  b_desc_q;

    assign op = instr.op;

    // fetch always sees the last configured regions
    assign cfg.a_desc = a_desc_q;
    assign cfg.b_desc = b_desc_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state    <= ST_IDLE;
            ack      <= 1'b0;
            cfg.req  <= 1'b0;
            a_desc_q <= '0;
            b_desc_q <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (instr_valid) begin
                        if (op == OP_MATRIX) begin
                            state <= ST_DISPATCH;
                        end else begin
                            if (op == OP_CONFIG) begin
                                a_desc_q <= instr.a_desc;
                                b_desc_q <= instr.b_desc;
                            end
                            // conv and unknown ops just get acked
                            ack   <= 1'b1;
                            state <= ST_ACKED;
                        end
                    end
                end
                ST_DISPATCH: begin
                    // fetch holds off its ack while a run is busy
                    if (cfg.req && cfg.ack) begin
                        cfg.req <= 1'b0;
                        ack     <= 1'b1;
                        state   <= ST_ACKED;
                    end else if (!cfg.ack) begin
                        cfg.req <= 1'b1;
                    end
                end
                ST_ACKED: begin
                    if (!instr_valid) begin
                        ack   <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/operand_fetch.sv
`default_nettype none

module operand_fetch import accel_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    fetch_cfg_if.fetch  cfg,
    output addr_t       a_rd_addr,
    input  wire word_t  a_rd_data,
    output addr_t       b_rd_addr,
    input  wire word_t  b_rd_data,
    pair_stream_if.src  pairs
);

    logic   busy;
    logic   first_pend;
    logic   idle;
    addr_t  a_addr;
    addr_t  b_addr;
    count_t remaining;
    count_t count;
    logic   beat_valid;
    logic   beat_first;
    logic   beat_last;

    assign count = count_t'(cfg.a_desc.channel) * count_t'(cfg.a_desc.row)
                 * count_t'(cfg.a_desc.col);

    // idle once the last beat has left the data stage
    assign idle = !busy && !beat_valid;

    assign a_rd_addr = a_addr;
    assign b_rd_addr = b_addr;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy       <= 1'b0;
            first_pend <= 1'b0;
            cfg.ack    <= 1'b0;
            a_addr     <= '0;
            b_addr     <= '0;
            remaining  <= '0;
            beat_valid <= 1'b0;
            beat_first <= 1'b0;
            beat_last  <= 1'b0;
        end else begin
            // data stage lines up with the buffer read latency
            beat_valid <= busy;
            beat_first <= busy && first_pend;
            beat_last  <= busy && (remaining == count_t'(1));

            if (busy) begin
                // 10-bit address wraps modulo the buffer depth
                a_addr     <= a_addr + addr_t'(1);
                b_addr     <= b_addr + addr_t'(1);
                remaining  <= remaining - count_t'(1);
                first_pend <= 1'b0;
                if (remaining == count_t'(1)) begin
                    busy <= 1'b0;
                end
            end else if (cfg.req && !cfg.ack && idle) begin
                a_addr     <= cfg.a_desc.src_addr;
                b_addr     <= cfg.b_desc.src_addr;
                remaining  <= count;
                busy       <= (count != '0);
                first_pend <= 1'b1;
                cfg.ack    <= 1'b1;
            end

            if (!cfg.req) begin
                cfg.ack <= 1'b0;
            end
        end
    end

    assign pairs.valid = beat_valid;
    assign pairs.first = beat_first;
    assign pairs.last  = beat_last;
    assign pairs.a     = a_rd_data;
    assign pairs.b     = b_rd_data;

endmodule

`default_nettype wire

//--- src/pair_stream_if.sv
`default_nettype none

interface pair_stream_if import accel_pkg::*; ();

    logic  valid;
    logic  first;
    logic  last;
    word_t a;
    word_t b;

    // no ready signal so the sink takes every valid beat
    modport src (
        output valid,
        output first,
        output last,
        output a,
        output b
    );

    modport dst (
        input valid,
        input first,
        input last,
        input a,
        input b
    );

endinterface

`default_nettype wire

//--- src/result_writer.sv
`default_nettype none

module result_writer import accel_pkg::*; (
    input  wire        clk,
    input  wire        rst,
    pair_stream_if.dst pairs,
    output logic       wr_en,
    output addr_t      wr_addr,
    output word_t      wr_a,
    output word_t      wr_b,
    output logic       done
);

    logic last_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_en   <= 1'b0;
            wr_addr <= '0;
            last_q  <= 1'b0;
            done    <= 1'b0;
        end else begin
            wr_en  <= pairs.valid;
            last_q <= pairs.valid && pairs.last;

            if (pairs.valid) begin
                wr_addr <= pairs.first ? '0 : wr_addr + addr_t'(1);
            end

            // done holds until the next run starts
            if (pairs.valid && pairs.first) begin
                done <= 1'b0;
            end else if (last_q) begin
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pairs.valid) begin
            wr_a <= pairs.a;
            wr_b <= pairs.b;
        end
    end

endmodule

`default_nettype wire

//--- src/word_sram.sv
`default_nettype none

module word_sram import accel_pkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire        wr_en,
    input  wire addr_t wr_addr,
    input  wire word_t wr_data,
    input  wire addr_t rd_addr,
    output word_t      rd_data
);

    word_t mem [BUF_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // same-address read during a write returns the old word
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rd_data <= '0;
        end else begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

//--- test/tb_accel.sv
`default_nettype none

module tb_accel import accel_pkg::*; ();

    localparam int CLK_PERIOD  = 100;
    localparam int TOTAL_ELEMS = 30 + 12 + 8 + 256 + 20;
    localparam int WATCHDOG_CYCLES = 200 * TOTAL_ELEMS + 2000;
    localparam int ACK_LIMIT   = 2000;
    localparam int DONE_LIMIT  = 2000;

    logic   clk;
    logic   rst;
    logic   instr_valid;
    instr_t instr;
    logic   load_en;
    logic   load_sel;
    addr_t  load_addr;
    word_t  load_data;
    addr_t  rd_addr;
    wire    ack;
    wire    done;
    word_t  out_a;
    word_t  out_b;

    word_t       a_mem [BUF_DEPTH];
    word_t       b_mem [BUF_DEPTH];
    word_t       exp_a [BUF_DEPTH];
    word_t       exp_b [BUF_DEPTH];
    int          written_len;
    int          mismatches;
    int          failures;
    logic [31:0] lcg_state;

    accel_top i_accel_top (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .load_en     (load_en),
        .load_sel    (load_sel),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .rd_addr     (rd_addr),
        .ack         (ack),
        .done        (done),
        .out_a       (out_a),
        .out_b       (out_b)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic desc_t make_desc(input addr_t base, input dim_t ch, input dim_t row,
                                        input dim_t col);
        desc_t d;
        d.src_addr = base;
        d.channel  = ch;
        d.row      = row;
        d.col      = col;
        return d;
    endfunction

    function automatic instr_t make_instr(input op_t op, input desc_t a, input desc_t b);
        instr_t ins;
        ins.op      = op;
        ins.wb_desc = '0;
        ins.a_desc  = a;
        ins.b_desc  = b;
        return ins;
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    // whole buffer from the LCG
    // model copy kept alongside
    task automatic load_buffer(input logic sel);
        int i;
        for (i = 0; i < BUF_DEPTH; i++) begin
            @(negedge clk);
            lcg_state = lcg_next(lcg_state);
            load_en   = 1'b1;
            load_sel  = sel;
            load_addr = addr_t'(i);
            load_data = lcg_state[31:16];
            if (sel) begin
                b_mem[i] = lcg_state[31:16];
            end else begin
                a_mem[i] = lcg_state[31:16];
            end
        end
        @(negedge clk);
        load_en = 1'b0;
    endtask

    task automatic send_instr(input instr_t ins, output time ack_time);
        int waited;
        ack_time = 0;
        @(negedge clk);
        instr       = ins;
        instr_valid = 1'b1;
        waited      = 0;
        while (!ack && waited < ACK_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!ack) begin
            failures++;
            $display("instruction op %0d was never acknowledged", ins.op);
            instr_valid = 1'b0;
        end else begin
            ack_time    = $time;
            instr_valid = 1'b0;
            waited      = 0;
            while (ack && waited < ACK_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (ack) begin
                failures++;
                $display("ack stayed high after instr_valid was dropped");
            end
        end
    endtask

    task automatic wait_done();
        int waited;
        waited = 0;
        while (!done && waited < DONE_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            failures++;
            $display("done never rose after the matrix run");
        end
    endtask

    task automatic read_out(input int len);
        int    i;
        addr_t first_bad;
        first_bad = addr_t'(len);
        for (i = 0; i < len; i++) begin
            @(negedge clk);
            rd_addr = addr_t'(i);
            @(negedge clk);
            check_word(out_a, exp_a[i], $sformatf("out_a[%0d]", i));
            check_word(out_b, exp_b[i], $sformatf("out_b[%0d]", i));
            if ((out_a !== exp_a[i] || out_b !== exp_b[i]) && first_bad == addr_t'(len)) begin
                first_bad = addr_t'(i);
            end
        end
        check_addr(first_bad, addr_t'(len), "first bad output address");
    endtask

    // expected output of a run
    // element count from the A dims only
    task automatic apply_run(input desc_t a, input desc_t b);
        int n;
        int i;
        n = int'(a.channel) * int'(a.row) * int'(a.col);
        for (i = 0; i < n; i++) begin
            exp_a[i] = a_mem[(int'(a.src_addr) + i) % BUF_DEPTH];
            exp_b[i] = b_mem[(int'(b.src_addr) + i) % BUF_DEPTH];
        end
        if (n > written_len) begin
            written_len = n;
        end
    endtask

    task automatic run_matrix(input desc_t a, input desc_t b);
        time unused;
        send_instr(make_instr(OP_CONFIG, a, b), unused);
        send_instr(make_instr(OP_MATRIX, '0, '0), unused);
        apply_run(a, b);
        wait_done();
        read_out(written_len);
    endtask

    task automatic reset_outputs();
        @(negedge clk);
        check_flag(ack, 1'b0, "ack after reset");
        check_flag(done, 1'b0, "done after reset");
    endtask

    task automatic basic_run();
        run_matrix(make_desc(10'd100, 8'd2, 8'd3, 8'd5), make_desc(10'd700, 8'd2, 8'd3, 8'd5));
    endtask

    task automatic address_wrap();
        run_matrix(make_desc(10'd1020, 8'd1, 8'd3, 8'd4), make_desc(10'd0, 8'd1, 8'd3, 8'd4));
    endtask

    // entries past 8 keep the older results
    // B dims differ from A and must not set the count
    task automatic reconfigure();
        run_matrix(make_desc(10'd40, 8'd1, 8'd2, 8'd4), make_desc(10'd512, 8'd2, 8'd3, 8'd4));
    endtask

    task automatic backpressure();
        time   ack_time;
        time   done_time;
        time   unused;
        desc_t big_a;
        desc_t big_b;
        desc_t small_a;
        desc_t small_b;
        big_a   = make_desc(10'd200, 8'd4, 8'd8, 8'd8);
        big_b   = make_desc(10'd900, 8'd4, 8'd8, 8'd8);
        small_a = make_desc(10'd600, 8'd2, 8'd2, 8'd5);
        small_b = make_desc(10'd333, 8'd2, 8'd2, 8'd5);
        send_instr(make_instr(OP_CONFIG, big_a, big_b), unused);
        send_instr(make_instr(OP_MATRIX, '0, '0), unused);
        apply_run(big_a, big_b);
        // config lands while the long run is still streaming
        send_instr(make_instr(OP_CONFIG, small_a, small_b), unused);
        done_time = 0;
        fork
            begin
                @(posedge done);
                done_time = $time;
            end
            send_instr(make_instr(OP_MATRIX, '0, '0), ack_time);
        join
        check_flag(done_time != 0 && ack_time >= done_time, 1'b1,
                   "matrix ack held until previous done");
        apply_run(small_a, small_b);
        wait_done();
        read_out(written_len);
    endtask

    task automatic conv_ignored();
        time unused;
        check_flag(done, 1'b1, "done before conv");
        send_instr(make_instr(OP_CONV, make_desc(10'd5, 8'd3, 8'd3, 8'd3),
                              make_desc(10'd9, 8'd3, 8'd3, 8'd3)), unused);
        check_flag(done, 1'b1, "done right after conv");
        repeat (20) @(negedge clk);
        check_flag(done, 1'b1, "done after conv settles");
        read_out(written_len);
    endtask

    initial begin
        rst         = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        load_en     = 1'b0;
        load_sel    = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        rd_addr     = '0;
        written_len = 0;
        mismatches  = 0;
        failures    = 0;
        lcg_state   = 32'hcb22f98a;
        repeat (16) @(negedge clk);
        rst = 1'b1;

        reset_outputs();
        load_buffer(1'b0);
        load_buffer(1'b1);
        basic_run();
        address_wrap();
        reconfigure();
        backpressure();
        conv_ignored();

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
